// ==== flist.f ====
hw/board_pkg.sv
hw/key_debounce.sv
hw/reset_req_regs.sv
hw/reset_pulse_gen.sv
hw/event_capture.sv
hw/board_ctrl_top.sv
tests/board_ctrl_assertions.sv
tests/tb_board_ctrl.sv

// ==== tests/tb_board_ctrl.sv ====
/* testbench for board_ctrl_top: register table over Wishbone, per-channel pulse widths,
   edge filtering on cold reset, w1c fired flags and key debounce with a short glitch */

`timescale 1ns/1ps

module tb_board_ctrl;

  import board_pkg::*;

  localparam int ACK_TIMEOUT  = 10;   // cycles
  localparam int IDLE_TIMEOUT = 200;
  localparam int NUM_ACCESS   = 12;

  // one register access with its expected read value
  typedef struct packed {
    logic        we;
    logic [1:0]  adr;
    logic [31:0] wdat;
    logic [31:0] exp;      // keys part only for rand_sw reads
    logic        rand_sw;  // fresh switches before the access
  } access_t;

  localparam access_t ACCESS_TABLE [NUM_ACCESS] = '{
    '{1'b1, 2'(REG_REQ),    32'h0000_0005, 32'h0, 1'b0},  // cold + debug
    '{1'b0, 2'(REG_REQ),    32'h0,         32'h5, 1'b0},
    '{1'b1, 2'(REG_REQ),    32'hffff_fffa, 32'h0, 1'b0},  // only 2:0 kept
    '{1'b0, 2'(REG_REQ),    32'h0,         32'h2, 1'b0},
    '{1'b0, 2'(REG_INPUTS), 32'h0,         32'h3, 1'b1},
    '{1'b1, 2'(REG_INPUTS), 32'hffff_ffff, 32'h0, 1'b0},  // read only
    '{1'b0, 2'(REG_INPUTS), 32'h0,         32'h3, 1'b1},
    '{1'b1, 2'd3,           32'h0000_0007, 32'h0, 1'b0},  // unmapped word
    '{1'b0, 2'd3,           32'h0,         32'h0, 1'b0},
    '{1'b1, 2'(REG_REQ),    32'h0,         32'h0, 1'b0},
    '{1'b0, 2'(REG_REQ),    32'h0,         32'h0, 1'b0},
    '{1'b0, 2'(REG_INPUTS), 32'h0,         32'h3, 1'b1}
  };

  localparam int EXP_WIDTH [NUM_RESET_CH] = '{6, 2, 32};  // cold, warm, debug

  logic                fpga_clk_50;
  logic                rst_n;
  logic [NUM_KEYS-1:0] key;
  logic [NUM_SW-1:0]   sw;
  wb_req_t             wb_req;
  wb_rsp_t             wb_rsp;
  reset_req_t          reset_req_n;
  stm_events_t         stm_events;

  integer     seed = 32'h27d1_ba03;
  int         low_cycles [NUM_RESET_CH] = '{0, 0, 0};  // running totals per channel
  int         fall_count [NUM_RESET_CH] = '{0, 0, 0};
  reset_req_t prev_n = '1;

  board_ctrl_top #(
    .DEBOUNCE_CYCLES (8)
  ) DUT (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .key         (key),
    .sw          (sw),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .reset_req_n (reset_req_n),
    .stm_events  (stm_events)
  );

  initial begin
    fpga_clk_50 = 1'b0;
    forever #2 fpga_clk_50 = ~fpga_clk_50;  // 4 ns period
  end

  // count low cycles and falling edges of each output
  always @(negedge fpga_clk_50) begin
    for (int i = 0; i < NUM_RESET_CH; i++) begin
      if (!reset_req_n[i]) low_cycles[i]++;
      if (prev_n[i] && !reset_req_n[i]) fall_count[i]++;
    end
    prev_n <= reset_req_n;
  end

  task automatic fail_run(input string reason);
    $display("%s", reason);
    $display("TESTS FAILED");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                             input string what);
    if (actual !== expected) begin
      fail_run($sformatf("mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                         $time, what, actual, expected));
    end
  endtask

  // ========================================
  // Wishbone master, called on a falling edge
  // ========================================
  task automatic wb_access(input logic we, input logic [1:0] adr, input logic [31:0] wdat,
                           output logic [31:0] rdat);
    int waited;
    wb_req.cyc   = 1'b1;
    wb_req.stb   = 1'b1;
    wb_req.we    = we;
    wb_req.adr   = adr;
    wb_req.dat_w = wdat;
    @(negedge fpga_clk_50);
    waited = 1;
    while (!wb_rsp.ack) begin
      if (waited >= ACK_TIMEOUT) begin
        fail_run("timeout: no Wishbone ack for a bus cycle");
      end else begin
        @(negedge fpga_clk_50);
        waited++;
      end
    end
    rdat   = wb_rsp.dat_r;  // valid with ack
    wb_req = '0;            // release before the next edge
  endtask

  task automatic wb_write(input logic [1:0] adr, input logic [31:0] wdat);
    logic [31:0] unused;
    wb_access(1'b1, adr, wdat, unused);
  endtask

  task automatic wb_read_check(input logic [1:0] adr, input logic [31:0] exp,
                               input string what);
    logic [31:0] rdat;
    wb_access(1'b0, adr, 32'h0, rdat);
    check_value(rdat, exp, what);
  endtask

  // all outputs high for a few cycles in a row, so no pulse is running
  task automatic wait_reset_idle();
    int quiet;
    int waited;
    quiet  = 0;
    waited = 0;
    while (quiet < 4) begin
      if (waited >= IDLE_TIMEOUT) begin
        fail_run("timeout: reset_req_n never returned to idle");
      end else begin
        @(negedge fpga_clk_50);
        waited++;
        quiet = (reset_req_n == '1) ? quiet + 1 : 0;
      end
    end
  endtask

  // delay from the ack edge and low time of one channel
  task automatic measure_pulse(input int ch);
    int         cycles;
    reset_req_t exp_n;
    reset_req_t exp_pulse;
    exp_n     = reset_req_t'(~(3'b001 << ch));
    exp_pulse = reset_req_t'(3'b001 << ch);  // active high in the trace word
    cycles    = 0;
    while (reset_req_n == '1) begin
      if (cycles >= ACK_TIMEOUT) begin
        fail_run("timeout: reset_req_n did not go low after the request");
      end else begin
        @(negedge fpga_clk_50);
        cycles++;
      end
    end
    check_value(32'(cycles), 32'd2, "cycles from ack edge to reset_req_n low");
    cycles = 0;
    while (reset_req_n != '1) begin
      check_value(32'(reset_req_n), 32'(exp_n), "only the requested bit is low");
      check_value(32'(stm_events.reset_pulse), 32'(exp_pulse), "reset_pulse field of stm_events");
      if (cycles >= 2 * MAX_PULSE_EXT) begin
        fail_run("timeout: reset_req_n stuck low");
      end else begin
        @(negedge fpga_clk_50);
        cycles++;
      end
    end
    check_value(32'(stm_events.reset_pulse), 32'h0, "reset_pulse field after the pulse");
    check_value(32'(cycles), 32'(EXP_WIDTH[ch]), $sformatf("pulse width of channel %0d", ch));
  endtask

  // wait for a value on the keys field of stm_events, returns cycles taken
  task automatic wait_keys(input logic [NUM_KEYS-1:0] want, output int cycles);
    cycles = 0;
    while (stm_events.keys != want) begin
      if (cycles >= 40) begin
        fail_run("timeout: debounced keys never reached stm_events");
      end else begin
        @(negedge fpga_clk_50);
        cycles++;
      end
    end
  endtask

  initial begin
    logic [31:0] exp;
    int          low_before [NUM_RESET_CH];
    int          fall_before [NUM_RESET_CH];
    int          cycles;

    rst_n  = 1'b0;
    key    = '1;  // released
    sw     = '0;
    wb_req = '0;
    repeat (16) @(negedge fpga_clk_50);
    rst_n = 1'b1;
    @(negedge fpga_clk_50);

    // ========================================
    // state after reset
    // ========================================
    check_value(32'(reset_req_n), 32'h7, "reset_req_n after reset");
    check_value(32'(stm_events.pad), 32'h0, "stm_events pad after reset");
    wb_read_check(2'(REG_REQ), 32'h0, "REG_REQ after reset");
    wb_read_check(2'(REG_FIRED), 32'h0, "REG_FIRED after reset");

    // register table
    for (int i = 0; i < NUM_ACCESS; i++) begin
      if (ACCESS_TABLE[i].rand_sw) sw = NUM_SW'($random(seed));
      if (ACCESS_TABLE[i].we) begin
        wb_write(ACCESS_TABLE[i].adr, ACCESS_TABLE[i].wdat);
      end else begin
        exp = ACCESS_TABLE[i].exp;
        if (ACCESS_TABLE[i].rand_sw) exp = exp | (32'(sw) << NUM_KEYS);  // switches in 5:2
        wb_read_check(ACCESS_TABLE[i].adr, exp, $sformatf("table entry %0d", i));
      end
    end
    wait_reset_idle();

    // ========================================
    // pulse width per channel
    // ========================================
    wb_write(2'(REG_FIRED), 32'h7);  // table writes already fired every channel
    for (int ch = 0; ch < NUM_RESET_CH; ch++) begin
      wb_write(2'(REG_REQ), 32'h0);
      wait_reset_idle();
      wb_write(2'(REG_REQ), 32'h1 << ch);
      measure_pulse(ch);
    end
    wb_read_check(2'(REG_FIRED), 32'h7, "fired flags after all channels");
    wb_write(2'(REG_FIRED), 32'h7);
    wb_read_check(2'(REG_FIRED), 32'h0, "fired flags after w1c");

    // cold request bouncing: raise, drop, raise on back-to-back writes
    wb_write(2'(REG_REQ), 32'h0);
    wait_reset_idle();
    low_before  = low_cycles;
    fall_before = fall_count;
    wb_write(2'(REG_REQ), 32'h1);
    wb_write(2'(REG_REQ), 32'h0);
    wb_write(2'(REG_REQ), 32'h1);
    wait_reset_idle();
    check_value(32'(fall_count[0] - fall_before[0]), 32'd1, "cold pulses after bounce");
    check_value(32'(low_cycles[0] - low_before[0]), 32'd6, "cold low time after bounce");
    check_value(32'(low_cycles[1] - low_before[1]), 32'd0, "warm untouched");
    check_value(32'(low_cycles[2] - low_before[2]), 32'd0, "debug untouched");
    wb_read_check(2'(REG_FIRED), 32'h1, "cold fired flag set");
    wb_write(2'(REG_FIRED), 32'h1);
    wb_read_check(2'(REG_FIRED), 32'h0, "cold fired flag cleared");

    // ========================================
    // key debounce
    // ========================================
    sw  = NUM_SW'($random(seed));
    key = 2'b10;  // 5-cycle glitch on key 0
    repeat (5) @(negedge fpga_clk_50);
    key = 2'b11;
    for (int i = 0; i < 12; i++) begin
      @(negedge fpga_clk_50);
      check_value(32'(stm_events.keys), 32'h3, "keys field during glitch");
    end
    wb_read_check(2'(REG_INPUTS), (32'(sw) << NUM_KEYS) | 32'h3, "REG_INPUTS after glitch");

    key = 2'b01;  // hold key 1 down
    wait_keys(2'b01, cycles);
    check_value(32'(cycles), 32'd9, "debounce time plus capture");  // 8 + 1 register
    check_value(32'(stm_events.sw), 32'(sw), "switches in stm_events");
    check_value(32'(stm_events.pad), 32'h0, "stm_events pad");
    wb_read_check(2'(REG_INPUTS), (32'(sw) << NUM_KEYS) | 32'h1, "REG_INPUTS with key 1 held");
    key = 2'b11;
    wait_keys(2'b11, cycles);

    if (DUT.u_assertions.fail_count != 0) begin
      fail_run("one or more concurrent assertions failed");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// ==== tests/board_ctrl_assertions.sv ====
/* concurrent checks on the Wishbone handshake and the active-low reset outputs;
   bound into board_ctrl_top, sampled on the falling edge where DUT outputs are settled */

`timescale 1ns/1ps

module board_ctrl_assertions (
  input logic                  fpga_clk_50,
  input logic                  rst_n,
  input board_pkg::wb_req_t    wb_req,
  input board_pkg::wb_rsp_t    wb_rsp,
  input board_pkg::reset_req_t reset_req_n
);

  import board_pkg::*;

  int unsigned fail_count = 0;  // read by the testbench at the end

  // ========================================
  // Wishbone handshake
  // ========================================
  ack_needs_cyc_stb: assert property (@(negedge fpga_clk_50) disable iff (!rst_n)
    wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
  else begin
    fail_count++;
    $error("ack high without cyc and stb");
  end

  ack_single_cycle: assert property (@(negedge fpga_clk_50) disable iff (!rst_n)
    wb_rsp.ack |=> !wb_rsp.ack)
  else begin
    fail_count++;
    $error("ack held for two cycles");
  end

  // ========================================
  // reset request outputs
  // ========================================
  for (genvar ch = 0; ch < NUM_RESET_CH; ch++) begin : g_req_n
    low_time_bounded: assert property (@(negedge fpga_clk_50) disable iff (!rst_n)
      $fell(reset_req_n[ch]) |-> ##[1:MAX_PULSE_EXT] reset_req_n[ch])
    else begin
      fail_count++;
      $error("reset_req_n[%0d] low longer than the widest pulse", ch);
    end
  end

  // outputs parked high while the board is in reset
  idle_in_reset: assert property (@(negedge fpga_clk_50)
    !rst_n |-> (reset_req_n == '1))
  else begin
    fail_count++;
    $error("reset_req_n low while rst_n low");
  end

endmodule

bind board_ctrl_top board_ctrl_assertions u_assertions (
  .fpga_clk_50 (fpga_clk_50),
  .rst_n       (rst_n),
  .wb_req      (wb_req),
  .wb_rsp      (wb_rsp),
  .reset_req_n (reset_req_n)
);

// ==== hw/board_ctrl_top.sv ====
/* board-side control logic top: key debounce, Wishbone reset request registers,
   per-channel pulse stretchers and the event capture stage */

`timescale 1ns/1ps

module board_ctrl_top #(
  parameter int DEBOUNCE_CYCLES = board_pkg::DEBOUNCE_CYCLES_DEFAULT
) (
  input  logic                           fpga_clk_50,
  input  logic                           rst_n,
  input  logic [board_pkg::NUM_KEYS-1:0] key,
  input  logic [board_pkg::NUM_SW-1:0]   sw,
  input  board_pkg::wb_req_t             wb_req,
  output board_pkg::wb_rsp_t             wb_rsp,
  output board_pkg::reset_req_t          reset_req_n,
  output board_pkg::stm_events_t         stm_events
);

  import board_pkg::*;

  logic [NUM_KEYS-1:0] keys_db;    // debounced, active low
  reset_req_t          req_level;  // from REG_REQ
  reset_req_t          fired_clr;  // w1c strobe
  reset_req_t          fired;      // sticky flags for readback
  wire reset_req_t     pulses;     // one driver per channel bit

  // ========================================
  // input conditioning and registers
  // ========================================
  key_debounce #(
    .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
  ) u_key_debounce (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .keys_raw    (key),
    .keys_db     (keys_db)
  );

  reset_req_regs u_regs (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .keys_db     (keys_db),
    .sw          (sw),
    .fired       (fired),
    .req_level   (req_level),
    .fired_clr   (fired_clr)
  );

  // ========================================
  // cold / warm / debug stretchers
  // ========================================
  for (genvar ch = 0; ch < NUM_RESET_CH; ch++) begin : g_pulse
    reset_pulse_gen #(
      .PULSE_EXT (PULSE_EXT_TABLE[ch])  // 6, 2, 32
    ) u_pulse (
      .fpga_clk_50 (fpga_clk_50),
      .rst_n       (rst_n),
      .req         (req_level[ch]),
      .pulse       (pulses[ch])
    );
  end

  event_capture u_capture (
    .fpga_clk_50 (fpga_clk_50),
    .rst_n       (rst_n),
    .pulses      (pulses),
    .fired_clr   (fired_clr),
    .keys_db     (keys_db),
    .sw          (sw),
    .fired       (fired),
    .reset_req_n (reset_req_n),
    .stm_events  (stm_events)
  );

endmodule

// ==== hw/event_capture.sv ====
/* registers the active-low reset request outputs, keeps the sticky fired flags
   and builds the trace event word from switches, keys and reset pulses */

`timescale 1ns/1ps

module event_capture (
  input  logic                           fpga_clk_50,
  input  logic                           rst_n,
  input  board_pkg::reset_req_t          pulses,
  input  board_pkg::reset_req_t          fired_clr,
  input  logic [board_pkg::NUM_KEYS-1:0] keys_db,
  input  logic [board_pkg::NUM_SW-1:0]   sw,
  output board_pkg::reset_req_t          fired,
  output board_pkg::reset_req_t          reset_req_n,
  output board_pkg::stm_events_t         stm_events
);

  import board_pkg::*;

  reset_req_t  fired_q;  // sticky per channel
  reset_req_t  req_n_q;  // to the SoC, active low
  stm_events_t ev_q;

  // ========================================
  // reset outputs and fired flags
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      req_n_q <= '1;  // nothing requested
      fired_q <= '0;
    end else begin
      req_n_q <= reset_req_t'(~pulses);
      // set wins over a clear in the same cycle
      fired_q <= reset_req_t'((fired_q & ~fired_clr) | pulses);
    end
  end

  // ========================================
  // trace event word
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      ev_q.pad         <= '0;
      ev_q.sw          <= '0;
      ev_q.reset_pulse <= '0;
      ev_q.keys        <= '1;  // keys released
    end else begin
      ev_q.pad         <= '0;
      ev_q.sw          <= sw;
      ev_q.reset_pulse <= pulses;   // active high here
      ev_q.keys        <= keys_db;
    end
  end

  assign fired       = fired_q;
  assign reset_req_n = req_n_q;
  assign stm_events  = ev_q;

endmodule

// ==== hw/reset_pulse_gen.sv ====
/* turns a rising edge of req into a pulse exactly PULSE_EXT cycles wide;
   edges that arrive while the pulse is running are dropped */

`timescale 1ns/1ps

module reset_pulse_gen #(
  parameter int PULSE_EXT = board_pkg::MAX_PULSE_EXT
) (
  input  logic fpga_clk_50,
  input  logic rst_n,
  input  logic req,
  output logic pulse
);

  import board_pkg::*;

  // counter sized for the widest channel
  localparam int CNT_W = $clog2(MAX_PULSE_EXT + 1);

  logic             req_q;    // previous request level
  logic             rise;
  logic             busy;
  logic [CNT_W-1:0] remain;   // cycles left in the pulse

  assign rise = req & ~req_q;
  assign busy = (remain != '0);

  // ========================================
  // edge detect and down counter
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      req_q  <= 1'b0;
      remain <= '0;
    end else begin
      req_q <= req;
      if (busy) begin
        remain <= remain - 1'b1;  // new edges ignored here
      end else if (rise) begin
        remain <= CNT_W'(PULSE_EXT);  // load only when idle
      end
    end
  end

  // high for PULSE_EXT cycles after the load
  assign pulse = busy;

endmodule

// ==== hw/reset_req_regs.sv ====
/* Wishbone classic slave with the reset request register, the w1c fired flags
   and a readback of keys and switches; one registered ack per bus cycle */

`timescale 1ns/1ps

module reset_req_regs (
  input  logic                           fpga_clk_50,
  input  logic                           rst_n,
  input  board_pkg::wb_req_t             wb_req,
  output board_pkg::wb_rsp_t             wb_rsp,
  input  logic [board_pkg::NUM_KEYS-1:0] keys_db,
  input  logic [board_pkg::NUM_SW-1:0]   sw,
  input  board_pkg::reset_req_t          fired,
  output board_pkg::reset_req_t          req_level,
  output board_pkg::reset_req_t          fired_clr
);

  import board_pkg::*;

  logic                 ack_q;     // registered ack
  logic                 access;    // first cycle of a bus cycle
  logic                 wr_en;
  reset_req_t           req_q;     // request levels
  reset_req_t           clr_q;     // one-cycle clear strobe
  logic [WB_DATA_W-1:0] rd_data;

  // ========================================
  // bus handshake and writes
  // ========================================
  assign access = wb_req.cyc & wb_req.stb & ~ack_q;  // not yet acked
  assign wr_en  = access & wb_req.we;

  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      ack_q <= 1'b0;
      req_q <= '0;
      clr_q <= '0;
    end else begin
      ack_q <= access;  // ack lasts one cycle
      clr_q <= '0;      // strobe by default
      if (wr_en && wb_req.adr == WB_ADDR_W'(REG_REQ)) begin
        req_q <= reset_req_t'(wb_req.dat_w[NUM_RESET_CH-1:0]);
      end
      // write 1 to clear, handled in event_capture
      if (wr_en && wb_req.adr == WB_ADDR_W'(REG_FIRED)) begin
        clr_q <= reset_req_t'(wb_req.dat_w[NUM_RESET_CH-1:0]);
      end
      // REG_INPUTS and unmapped words drop writes
    end
  end

  // ========================================
  // read mux
  // ========================================
  always_comb begin
    rd_data = '0;  // unmapped reads zero
    case (wb_req.adr)
      WB_ADDR_W'(REG_REQ): begin
        rd_data[NUM_RESET_CH-1:0] = req_q;
      end
      WB_ADDR_W'(REG_FIRED): begin
        rd_data[NUM_RESET_CH-1:0] = fired;
      end
      WB_ADDR_W'(REG_INPUTS): begin
        rd_data[NUM_SW+NUM_KEYS-1:0] = {sw, keys_db};  // keys in 1:0
      end
      default: begin
        rd_data = '0;
      end
    endcase
  end

  // ack drops as soon as the master lets go of cyc or stb
  always_comb begin
    wb_rsp.ack   = ack_q & wb_req.cyc & wb_req.stb;
    wb_rsp.dat_r = wb_rsp.ack ? rd_data : '0;  // valid with ack only
  end

  assign req_level = req_q;
  assign fired_clr = clr_q;

endmodule

// ==== hw/key_debounce.sv ====
/* debounces the active-low push buttons; each bit only follows the raw input
   after it has held a new value for DEBOUNCE_CYCLES consecutive clocks */

`timescale 1ns/1ps

module key_debounce #(
  parameter int DEBOUNCE_CYCLES = board_pkg::DEBOUNCE_CYCLES_DEFAULT
) (
  input  logic                          fpga_clk_50,
  input  logic                          rst_n,
  input  logic [board_pkg::NUM_KEYS-1:0] keys_raw,
  output logic [board_pkg::NUM_KEYS-1:0] keys_db
);

  import board_pkg::*;

  // counter must hold DEBOUNCE_CYCLES-1
  localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

  logic [CNT_W-1:0]    stable_cnt [NUM_KEYS];  // cycles raw has differed
  logic [NUM_KEYS-1:0] keys_q;                 // debounced state

  // ========================================
  // per-key stability counter
  // ========================================
  always_ff @(posedge fpga_clk_50) begin
    if (!rst_n) begin
      keys_q <= '1;  // released
      for (int i = 0; i < NUM_KEYS; i++) begin
        stable_cnt[i] <= '0;
      end
    end else begin
      for (int i = 0; i < NUM_KEYS; i++) begin
        if (keys_raw[i] == keys_q[i]) begin
          stable_cnt[i] <= '0;  // glitch over, start again
        end else if (stable_cnt[i] == CNT_W'(DEBOUNCE_CYCLES - 1)) begin
          // held long enough
          keys_q[i]     <= keys_raw[i];
          stable_cnt[i] <= '0;
        end else begin
          stable_cnt[i] <= stable_cnt[i] + 1'b1;
        end
      end
    end
  end

  assign keys_db = keys_q;

endmodule

// ==== hw/board_pkg.sv ====
/* shared register map, timing constants and bus/event structs for the board control logic.
   import into any module that touches the Wishbone port, the reset channels or the trace word */

package board_pkg;

  // ========================================
  // reset request channels
  // ========================================
  localparam int NUM_RESET_CH = 3;  // cold = 0, warm = 1, debug = 2

  // pulse width per channel, in fpga_clk_50 cycles
  localparam int PULSE_EXT_TABLE [NUM_RESET_CH] = '{6, 2, 32};
  localparam int MAX_PULSE_EXT = 32;  // sizes the stretch counter

  // ========================================
  // board inputs
  // ========================================
  localparam int NUM_KEYS = 2;  // active-low push buttons
  localparam int NUM_SW   = 4;  // slide switches

  // 1 ms at 50 MHz
  localparam int DEBOUNCE_CYCLES_DEFAULT = 50000;

  // ========================================
  // Wishbone register map
  // ========================================
  localparam int WB_ADDR_W = 2;   // word address
  localparam int WB_DATA_W = 32;

  localparam int REG_REQ    = 0;  // rw, request levels
  localparam int REG_FIRED  = 1;  // r, w1c sticky flags
  localparam int REG_INPUTS = 2;  // ro, {sw, keys}

  // one bit per channel, cold in bit 0
  typedef struct packed {
    logic debug;
    logic warm;
    logic cold;
  } reset_req_t;

  // master to slave
  typedef struct packed {
    logic                 cyc;
    logic                 stb;
    logic                 we;
    logic [WB_ADDR_W-1:0] adr;
    logic [WB_DATA_W-1:0] dat_w;
  } wb_req_t;

  // slave to master
  typedef struct packed {
    logic                 ack;
    logic [WB_DATA_W-1:0] dat_r;
  } wb_rsp_t;

  // 28-bit hardware event word for the trace module
  typedef struct packed {
    logic [18:0]         pad;          // always zero
    logic [NUM_SW-1:0]   sw;
    reset_req_t          reset_pulse;  // took the old LED field
    logic [NUM_KEYS-1:0] keys;         // debounced, active low
  } stm_events_t;

endpackage
